/* prefetch_cfg.svh */
// build-time configuration of the instruction prefetch buffer
// included by the package and by every RTL file of the fetch stage
// change the values here to resize the queue or the memory port

`ifndef PREFETCH_CFG_SVH
`define PREFETCH_CFG_SVH

// fetch queue entries, 2 or more
`define FETCH_DEPTH 4
// 1: a response into an empty queue is visible on the core port at once
`define FETCH_FALL_THROUGH 1'b0
// requests allowed in flight towards instruction memory
`define FETCH_MAX_OUTSTANDING 4

// memory port widths
`define FETCH_ADDR_W 32
`define FETCH_INSTR_W 32

// queue pointer and occupancy widths, derived from the depth
`define FETCH_PTR_W $clog2(`FETCH_DEPTH)
`define FETCH_CNT_W (`FETCH_PTR_W + 1)

`endif

/* prefetch_pkg.sv */
// types shared by the prefetch controller, the fetch queue and the top level
// compile before any of the RTL modules

`include "prefetch_cfg.svh"

package prefetch_pkg;

    // byte address of an instruction, always word-aligned
    typedef logic [`FETCH_ADDR_W-1:0] addr_t;

    // raw instruction word from memory
    typedef logic [`FETCH_INSTR_W-1:0] instr_t;

    // queue element: address on top, instruction below
    typedef logic [`FETCH_ADDR_W+`FETCH_INSTR_W-1:0] fetch_entry_t;

    // queue occupancy, 0 up to the full depth
    typedef logic [`FETCH_CNT_W-1:0] fifo_cnt_t;

    // requests in flight and requests to throw away
    typedef logic [2:0] os_cnt_t;

    // controller state
    // REDIRECT while responses of an old stream are still on their way
    typedef enum logic {
        RUN,
        REDIRECT
    } fetch_state_e;

endpackage

/* fetch_fifo.sv */
// circular queue holding fetched instructions with their addresses
// flush empties it, flush_but_first keeps only the head entry
// with fall-through set, a push into an empty queue shows on data_o at once

`timescale 1ns/1ps
`include "prefetch_cfg.svh"

module fetch_fifo (
    input  logic                       clk_i,
    input  logic                       rst_ni,
    input  logic                       flush_i,
    input  logic                       flush_but_first_i,
    input  logic                       push_i,
    input  prefetch_pkg::fetch_entry_t data_i,
    input  logic                       pop_i,
    output prefetch_pkg::fetch_entry_t data_o,
    output logic                       full_o,
    output logic                       empty_o,
    output prefetch_pkg::fifo_cnt_t    usage_o
);
    import prefetch_pkg::*;

    localparam int unsigned DEPTH        = `FETCH_DEPTH;
    localparam bit          FALL_THROUGH = `FETCH_FALL_THROUGH;
    localparam int unsigned PTR_W        = `FETCH_PTR_W;
    localparam int unsigned CNT_W        = `FETCH_CNT_W;

    // read points at the head, write at the next free slot
    logic [PTR_W-1:0] rd_ptr_q;
    logic [PTR_W-1:0] rd_ptr_d;
    logic [PTR_W-1:0] wr_ptr_q;
    logic [PTR_W-1:0] wr_ptr_d;
    fifo_cnt_t        cnt_q;
    fifo_cnt_t        cnt_d;

    // entry storage
    fetch_entry_t     mem_q [DEPTH];

    logic             push_ok;
    logic             pop_ok;
    logic             bypass;
    logic             keep_head;

    // wrap by hand so depths that are not a power of two work too
    function automatic logic [PTR_W-1:0] ptr_inc(input logic [PTR_W-1:0] ptr);
        logic [PTR_W-1:0] nxt;
        if (ptr == PTR_W'(DEPTH - 1)) begin
            nxt = '0;
        end else begin
            nxt = ptr + 1'b1;
        end
        return nxt;
    endfunction

    // incoming word into an empty queue goes straight out in fall-through mode
    assign bypass  = FALL_THROUGH && (cnt_q == '0) && push_i;

    assign full_o  = (cnt_q == CNT_W'(DEPTH));
    assign empty_o = (cnt_q == '0) && !bypass;
    assign usage_o = cnt_q;

    // push when full and pop when empty are ignored
    assign push_ok = push_i && !full_o;
    assign pop_ok  = pop_i && !empty_o;

    assign data_o  = bypass ? data_i : mem_q[rd_ptr_q];

    // head survives a flush_but_first unless the core takes it this cycle
    // the bypassed word counts as the head since it lands at rd_ptr_q
    assign keep_head = ((cnt_q != '0) || bypass) && !pop_ok;

    always_comb begin
        rd_ptr_d = rd_ptr_q;
        wr_ptr_d = wr_ptr_q;
        cnt_d    = cnt_q;

        if (bypass && pop_ok) begin
            // word goes straight through to the core
            // pointers and count stay as they are
        end else begin
            if (push_ok) begin
                wr_ptr_d = ptr_inc(wr_ptr_q);
            end
            if (pop_ok) begin
                rd_ptr_d = ptr_inc(rd_ptr_q);
            end
            // push and pop together leave the count alone
            case ({push_ok, pop_ok})
                2'b10:   cnt_d = cnt_q + 1'b1;
                2'b01:   cnt_d = cnt_q - 1'b1;
                default: cnt_d = cnt_q;
            endcase
        end
    end

    always_ff @(posedge clk_i or negedge rst_ni) begin
        if (!rst_ni) begin
            rd_ptr_q <= '0;
            wr_ptr_q <= '0;
            cnt_q    <= '0;
        end else if (flush_i) begin
            // branch drops everything
            rd_ptr_q <= '0;
            wr_ptr_q <= '0;
            cnt_q    <= '0;
        end else if (flush_but_first_i) begin
            // hardware loop jump keeps the head and writes right behind it
            if (keep_head) begin
                rd_ptr_q <= rd_ptr_q;
                wr_ptr_q <= ptr_inc(rd_ptr_q);
                cnt_q    <= CNT_W'(1);
            end else begin
                rd_ptr_q <= '0;
                wr_ptr_q <= '0;
                cnt_q    <= '0;
            end
        end else begin
            rd_ptr_q <= rd_ptr_d;
            wr_ptr_q <= wr_ptr_d;
            cnt_q    <= cnt_d;
        end
    end

    // slot written on every accepted push
    // a word written during a flush is simply never read
    always_ff @(posedge clk_i) begin
        if (push_ok) begin
            mem_q[wr_ptr_q] <= data_i;
        end
    end

endmodule

/* prefetch_ctrl.sv */
// fetch controller: issues word reads to instruction memory within the credit
// of the queue, tags each returned word with its address and pushes it
// redirects flush the queue and discard responses of the old stream

`timescale 1ns/1ps
`include "prefetch_cfg.svh"

module prefetch_ctrl (
    input  logic                       clk_i,
    input  logic                       rst_ni,
    input  logic                       branch_i,
    input  prefetch_pkg::addr_t        branch_addr_i,
    input  logic                       hwlp_jump_i,
    input  prefetch_pkg::addr_t        hwlp_addr_i,
    output logic                       mem_req_o,
    output prefetch_pkg::addr_t        mem_addr_o,
    input  logic                       mem_rvalid_i,
    input  prefetch_pkg::instr_t       mem_rdata_i,
    input  prefetch_pkg::fifo_cnt_t    fifo_usage_i,
    output logic                       fifo_push_o,
    output prefetch_pkg::fetch_entry_t fifo_entry_o,
    output logic                       fifo_flush_o,
    output logic                       fifo_flush_but_first_o
);
    import prefetch_pkg::*;

    // wide enough for queue usage plus outstanding requests
    localparam int unsigned SUM_W = ((`FETCH_CNT_W > 3) ? `FETCH_CNT_W : 3) + 1;

    fetch_state_e     state_q;
    fetch_state_e     state_d;
    addr_t            fetch_addr_q;
    addr_t            resp_addr_q;
    os_cnt_t          os_cnt_q;
    os_cnt_t          os_cnt_d;
    os_cnt_t          discard_q;
    os_cnt_t          discard_d;
    logic             fetch_en_q;

    logic             redirect;
    addr_t            redirect_addr;
    logic [SUM_W-1:0] credit_sum;
    logic             credit_ok;
    logic             req;
    logic             drop;

    // branch wins over a loop jump in the same cycle
    assign redirect      = branch_i || hwlp_jump_i;
    assign redirect_addr = branch_i ? branch_addr_i : hwlp_addr_i;

    assign fifo_flush_o           = branch_i;
    assign fifo_flush_but_first_o = hwlp_jump_i && !branch_i;

    // every word in flight already owns a queue slot
    assign credit_sum = SUM_W'(fifo_usage_i) + SUM_W'(os_cnt_q);
    assign credit_ok  = (credit_sum < SUM_W'(`FETCH_DEPTH))
                     && (os_cnt_q < os_cnt_t'(`FETCH_MAX_OUTSTANDING));

    // no request in the redirect cycle, the old address is dead
    // fetch_en_q holds requests off until the first edge after reset
    assign req        = fetch_en_q && credit_ok && !redirect;
    assign mem_req_o  = req;
    assign mem_addr_o = fetch_addr_q;

    // responses that belong to a stream before the last redirect
    assign drop = mem_rvalid_i && (state_q == REDIRECT);

    assign fifo_push_o  = mem_rvalid_i && !drop;
    assign fifo_entry_o = {resp_addr_q, mem_rdata_i};

    always_comb begin
        os_cnt_d  = os_cnt_q;
        discard_d = discard_q;
        state_d   = state_q;

        // one more out, one back, or both
        if (req && !mem_rvalid_i) begin
            os_cnt_d = os_cnt_q + 1'b1;
        end else if (!req && mem_rvalid_i) begin
            os_cnt_d = os_cnt_q - 1'b1;
        end

        // drain stale words, back to RUN with the last one
        if (drop) begin
            discard_d = discard_q - 1'b1;
            if (discard_q == os_cnt_t'(1)) begin
                state_d = RUN;
            end
        end

        // everything still in flight after this cycle is stale
        if (redirect) begin
            discard_d = os_cnt_d;
            state_d   = (os_cnt_d != '0) ? REDIRECT : RUN;
        end
    end

    always_ff @(posedge clk_i or negedge rst_ni) begin
        if (!rst_ni) begin
            state_q      <= RUN;
            fetch_addr_q <= '0;
            resp_addr_q  <= '0;
            os_cnt_q     <= '0;
            discard_q    <= '0;
            fetch_en_q   <= 1'b0;
        end else begin
            state_q    <= state_d;
            os_cnt_q   <= os_cnt_d;
            discard_q  <= discard_d;
            fetch_en_q <= 1'b1;
            if (redirect) begin
                // both streams restart at the target
                fetch_addr_q <= redirect_addr;
                resp_addr_q  <= redirect_addr;
            end else begin
                if (req) begin
                    fetch_addr_q <= fetch_addr_q + addr_t'(4);
                end
                // responses come back in order, so the tag just counts up
                if (fifo_push_o) begin
                    resp_addr_q <= resp_addr_q + addr_t'(4);
                end
            end
        end
    end

endmodule

/* prefetch_buffer.sv */
// instruction prefetch buffer of the fetch stage
// memory side: one-cycle read strobes, in-order responses of any latency
// core side: valid/ready with address and instruction, plus redirect strobes

`timescale 1ns/1ps
`include "prefetch_cfg.svh"

module prefetch_buffer (
    input  logic                 clk_i,
    input  logic                 rst_ni,
    input  logic                 branch_i,
    input  prefetch_pkg::addr_t  branch_addr_i,
    input  logic                 hwlp_jump_i,
    input  prefetch_pkg::addr_t  hwlp_addr_i,
    output logic                 mem_req_o,
    output prefetch_pkg::addr_t  mem_addr_o,
    input  logic                 mem_rvalid_i,
    input  prefetch_pkg::instr_t mem_rdata_i,
    output logic                 valid_o,
    output prefetch_pkg::addr_t  addr_o,
    output prefetch_pkg::instr_t instr_o,
    input  logic                 ready_i
);
    import prefetch_pkg::*;

    fifo_cnt_t    fifo_usage;
    logic         fifo_push;
    logic         fifo_flush;
    logic         fifo_flush_but_first;
    logic         fifo_empty;
    fetch_entry_t fifo_entry;
    fetch_entry_t fifo_head;

    prefetch_ctrl i_ctrl (
        .clk_i                  (clk_i),
        .rst_ni                 (rst_ni),
        .branch_i               (branch_i),
        .branch_addr_i          (branch_addr_i),
        .hwlp_jump_i            (hwlp_jump_i),
        .hwlp_addr_i            (hwlp_addr_i),
        .mem_req_o              (mem_req_o),
        .mem_addr_o             (mem_addr_o),
        .mem_rvalid_i           (mem_rvalid_i),
        .mem_rdata_i            (mem_rdata_i),
        .fifo_usage_i           (fifo_usage),
        .fifo_push_o            (fifo_push),
        .fifo_entry_o           (fifo_entry),
        .fifo_flush_o           (fifo_flush),
        .fifo_flush_but_first_o (fifo_flush_but_first)
    );

    // full is never reached with a push pending, the credit rule sees to it
    fetch_fifo i_fifo (
        .clk_i             (clk_i),
        .rst_ni            (rst_ni),
        .flush_i           (fifo_flush),
        .flush_but_first_i (fifo_flush_but_first),
        .push_i            (fifo_push),
        .data_i            (fifo_entry),
        .pop_i             (ready_i),
        .data_o            (fifo_head),
        .full_o            (),
        .empty_o           (fifo_empty),
        .usage_o           (fifo_usage)
    );

    // head of the queue straight to the core
    assign valid_o = !fifo_empty;
    assign addr_o  = fifo_head[`FETCH_ADDR_W+`FETCH_INSTR_W-1:`FETCH_INSTR_W];
    assign instr_o = fifo_head[`FETCH_INSTR_W-1:0];

endmodule

/* tb_prefetch_buffer.sv */
// testbench for the instruction prefetch buffer
// memory latency, core stalls and redirects come from an LFSR
// a model of the fetch stream checks every popped entry and every request

`timescale 1ns/1ps
`include "prefetch_cfg.svh"

module tb_prefetch_buffer;
    import prefetch_pkg::*;

    localparam int N_CYCLES     = 400;
    localparam int TOTAL_CYCLES = 8 + 1 + 5 * N_CYCLES;

    logic   clk_i         = 1'b0;
    logic   rst_ni        = 1'b0;
    logic   branch_i      = 1'b0;
    addr_t  branch_addr_i = '0;
    logic   hwlp_jump_i   = 1'b0;
    addr_t  hwlp_addr_i   = '0;
    logic   mem_req_o;
    addr_t  mem_addr_o;
    logic   mem_rvalid_i  = 1'b0;
    instr_t mem_rdata_i   = '0;
    logic   valid_o;
    addr_t  addr_o;
    instr_t instr_o;
    logic   ready_i       = 1'b0;

    logic [31:0] lfsr_q = 32'h6f01_cc70;
    // requests waiting in the memory model for their response cycle
    addr_t       pend_addr [$];
    int          pend_due [$];
    int          last_due, cycle_cnt, stall_left;
    logic        stall_low;
    // stream model
    addr_t       exp_addr, req_addr, kept_addr;
    logic        kept;
    int          n_req, n_pop, n_disc, n_err, n_chk, n_event;

    prefetch_buffer DUT (.*);

    always #5 clk_i = ~clk_i;

    // taps 32, 22, 2, 1
    function automatic logic lfsr_bit();
        lfsr_q = {lfsr_q[30:0], lfsr_q[31] ^ lfsr_q[21] ^ lfsr_q[1] ^ lfsr_q[0]};
        return lfsr_q[0];
    endfunction

    function automatic logic [31:0] rand_bits(input int n);
        logic [31:0] v;
        v = '0;
        for (int i = 0; i < n; i++) begin
            v = {v[30:0], lfsr_bit()};
        end
        return v;
    endfunction

    // memory word is the address xor a constant rotated left by 13
    function automatic instr_t scramble(input addr_t a);
        logic [31:0] x;
        x = a ^ 32'h5a3c_96e1;
        return {x[18:0], x[31:19]};
    endfunction

    task automatic check_word(input string name, input logic [31:0] got,
                              input logic [31:0] exp);
        n_chk++;
        assert (got === exp) else begin
            $display("[FAIL] %0t ns %s: got %h, expected %h", $time, name, got, exp);
            n_err++;
        end
    endtask

    task automatic check_true(input logic ok, input string what);
        n_chk++;
        assert (ok) else begin
            $display("error at %0t ns: %s", $time, what);
            n_err++;
        end
    endtask

    // drive one clock on the falling edge and sample once the logic settles
    task automatic run_cycle(input logic br_en, input logic hw_en, input logic stalls);
        int    lat;
        int    due;
        addr_t exp_a;
        @(negedge clk_i);
        cycle_cnt++;
        mem_rvalid_i = 1'b0;
        if (pend_due.size() > 0 && pend_due[0] <= cycle_cnt) begin
            mem_rvalid_i = 1'b1;
            mem_rdata_i  = scramble(pend_addr[0]);
            void'(pend_due.pop_front());
            void'(pend_addr.pop_front());
        end
        // long low stretches with short bursts of ready in between
        if (stalls) begin
            if (stall_left == 0) begin
                stall_low  = !stall_low;
                stall_left = stall_low ? 8 + int'(rand_bits(4)) : 2 + int'(rand_bits(3));
                n_event++;
            end
            stall_left--;
            ready_i = !stall_low;
        end else begin
            ready_i = (rand_bits(2) != 0);
        end
        branch_i      = br_en && (rand_bits(4) == 0);
        hwlp_jump_i   = hw_en && (rand_bits(4) == 0);
        branch_addr_i = rand_bits(12) << 2;
        hwlp_addr_i   = rand_bits(12) << 2;
        #2;
        // a kept head comes out before the loop target
        if ((valid_o === 1'b1) && ready_i) begin
            exp_a = kept ? kept_addr : exp_addr;
            check_word("addr_o", addr_o, exp_a);
            check_word("instr_o", instr_o, scramble(exp_a));
            if (kept) begin
                kept = 1'b0;
            end else begin
                exp_addr += 4;
            end
            n_pop++;
        end
        if (branch_i || hwlp_jump_i) begin
            check_word("mem_req_o", 32'(mem_req_o), 0);
        end
        if (mem_req_o === 1'b1) begin
            check_word("mem_addr_o", mem_addr_o, req_addr);
            lat = 1 + int'(rand_bits(2));
            due = cycle_cnt + lat;
            if (due <= last_due) begin
                due = last_due + 1;
            end
            last_due = due;
            pend_addr.push_back(mem_addr_o);
            pend_due.push_back(due);
            req_addr += 4;
            n_req++;
        end
        // branch wins and otherwise an unpopped head survives the loop jump
        if (branch_i) begin
            kept     = 1'b0;
            exp_addr = branch_addr_i;
        end else if (hwlp_jump_i) begin
            if ((valid_o === 1'b1) && !ready_i) begin
                kept_addr = kept ? kept_addr : exp_addr;
                kept      = 1'b1;
            end else begin
                kept = 1'b0;
            end
            exp_addr = hwlp_addr_i;
        end
        if (branch_i || hwlp_jump_i) begin
            req_addr = exp_addr;
            n_disc   = n_req - n_pop - int'(kept);
            n_event++;
        end
        // live words queued or in flight fit in the queue
        check_true(n_req - n_pop - n_disc <= `FETCH_DEPTH,
                   "more live words fetched than the queue can hold");
    endtask

    task automatic run_test(input int num, input string name, input logic br_en,
                            input logic hw_en, input logic stalls);
        int err0;
        int pop0;
        int ev0;
        err0 = n_err;
        pop0 = n_pop;
        ev0  = n_event;
        repeat (N_CYCLES) run_cycle(br_en, hw_en, stalls);
        check_true(n_pop > pop0, "no instruction reached the core during the test");
        if (br_en || hw_en || stalls) begin
            check_true(n_event > ev0, "no redirect or stall happened during the test");
        end
        $display("test %0d %s: %0d pops, %0d errors", num, name, n_pop - pop0, n_err - err0);
    endtask

    initial begin
        exp_addr   = '0;
        req_addr   = '0;
        kept_addr  = '0;
        kept       = 1'b0;
        stall_low  = 1'b0;
        stall_left = 0;
        // outputs stay quiet during reset and right at the release
        repeat (8) begin
            @(negedge clk_i);
            check_word("mem_req_o", 32'(mem_req_o), 0);
            check_word("valid_o", 32'(valid_o), 0);
        end
        rst_ni = 1'b1;
        #2;
        check_word("mem_req_o", 32'(mem_req_o), 0);
        check_word("valid_o", 32'(valid_o), 0);
        run_cycle(1'b0, 1'b0, 1'b0);
        check_word("mem_req_o", 32'(mem_req_o), 1);
        $display("test 1 reset: %0d errors", n_err);
        run_test(2, "sequential stream", 1'b0, 1'b0, 1'b0);
        run_test(3, "branch", 1'b1, 1'b0, 1'b0);
        run_test(4, "hardware loop jump", 1'b0, 1'b1, 1'b0);
        run_test(5, "back-pressure", 1'b1, 1'b1, 1'b1);
        run_test(6, "stream after back-pressure", 1'b0, 1'b0, 1'b0);
        $display("summary: %0d checks, %0d errors, %0d requests, %0d pops, %0d discarded",
                 n_chk, n_err, n_req, n_pop, n_disc);
        if (n_err == 0) begin
            $display("*** PASSED ***");
        end else begin
            $display("*** FAILED ***");
        end
        $finish;
    end

    // twice the stimulus length
    initial begin
        #(TOTAL_CYCLES * 20);
        $display("error: watchdog expired, the run did not finish in time");
        $display("*** FAILED ***");
        $finish;
    end

endmodule

/* prefetch_buffer.f */
+incdir+.
prefetch_pkg.sv
fetch_fifo.sv
prefetch_ctrl.sv
prefetch_buffer.sv
tb_prefetch_buffer.sv

/* Makefile */
VERILATOR ?= verilator
FLAGS     ?= --timing --assert
TOP       ?= tb_prefetch_buffer
RTL_TOP   ?= prefetch_buffer
FILELIST  ?= prefetch_buffer.f
BUILD_DIR ?= obj_dir
PASS_MSG  := *** PASSED ***

.PHONY: all lint sim clean

all: sim

lint:
	$(VERILATOR) --lint-only $(FLAGS) -f $(FILELIST) --top-module $(RTL_TOP)
	$(VERILATOR) --lint-only $(FLAGS) -f $(FILELIST) --top-module $(TOP)

sim:
	$(VERILATOR) --binary $(FLAGS) -f $(FILELIST) --top-module $(TOP) -Mdir $(BUILD_DIR)
	@out="$$(./$(BUILD_DIR)/V$(TOP))"; echo "$$out"; \
	echo "$$out" | grep -qF -- "$(PASS_MSG)"

clean:
	rm -rf $(BUILD_DIR)
